// File: src/mem_hub_pkg.sv
package mem_hub_pkg;

	// request tag width.
	localparam int CID_W = 6;
	// data word width.
	localparam int DATA_W = 64;
	// word address width.
	localparam int ADDR_W = 16;

	// response error code.
	typedef enum logic [1:0] {
		// access completed.
		ERR_OK    = 2'b00,
		// address beyond bank depth.
		ERR_ADDR  = 2'b01,
		// reserved codes.
		ERR_RSV2  = 2'b10,
		ERR_RSV3  = 2'b11
	} err_e;

	// request word, 87 bits.
	typedef struct packed {
		logic [CID_W-1:0]  cid;
		// 1 for read, 0 for write.
		logic              rnw;
		logic [ADDR_W-1:0] addr;
		// ignored on reads.
		logic [DATA_W-1:0] wdata;
	} req_t;

	// response status, 9 bits.
	typedef struct packed {
		logic [CID_W-1:0] cid;
		logic             rnw;
		err_e             err;
	} rss_t;

	// downstream skid FSM states.
	typedef enum logic [1:0] {
		// out of reset, enables the source read.
		SKID_IDLE = 2'b00,
		// waiting for a source item.
		SKID_RDXX = 2'b10,
		// output stalled, second item stashed.
		SKID_XXWR = 2'b01,
		// streaming source to sink.
		SKID_RDWR = 2'b11
	} skid_e;

endpackage

// File: src/mem_hub_fifo.sv
`timescale 1ns/1ps

module mem_hub_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             nrst,
	input  logic             i_push,
	input  logic [WIDTH-1:0] i_data,
	input  logic             i_pop,
	output logic [WIDTH-1:0] o_data,
	output logic             o_full,
	output logic             o_empty
);
	// pointer and occupancy widths.
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// storage array.
	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// flags straight from the count.
	assign o_full  = (count == CNT_W'(DEPTH));
	assign o_empty = (count == '0);
	// head entry always visible.
	assign o_data  = mem[rd_ptr];

	// pointers and count.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			// wrap at depth, no power of two needed.
			if (i_push)
			begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (i_pop)
			begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// push and pop together leave the count.
			case ({i_push, i_pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

	// write port.
	always_ff @(posedge clk)
	begin
		if (i_push)
		begin
			mem[wr_ptr] <= i_data;
		end
	end

	// producer must respect full.
	a_no_overflow: assert property (@(posedge clk) disable iff (!nrst)
		i_push |-> !o_full);
	// consumer must respect empty.
	a_no_underflow: assert property (@(posedge clk) disable iff (!nrst)
		i_pop |-> !o_empty);

endmodule

// File: src/mem_hub_channel.sv
`timescale 1ns/1ps

module mem_hub_channel
	import mem_hub_pkg::*;
#(
	parameter int MEM_DEPTH = 256,
	parameter int RSP_DEPTH = 4
) (
	input  logic              clk,
	input  logic              nrst,
	input  logic              i_req_vld,
	input  req_t              i_req,
	output logic              o_req_rd,
	output logic              o_rss_vld,
	output rss_t              o_rss,
	input  logic              i_rss_rd,
	output logic              o_rsd_vld,
	output logic [DATA_W-1:0] o_rsd,
	input  logic              i_rsd_rd
);
	// bank index width.
	localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

	// private RAM bank.
	logic [DATA_W-1:0] bank [MEM_DEPTH];
	logic              en_q;
	logic              req_fire;
	logic              in_range;
	logic [IDX_W-1:0]  idx;
	// request in flight toward the queues.
	logic              pend_q;
	rss_t              pend_rss;
	logic [DATA_W-1:0] rdata_q;
	logic              rss_full;
	logic              rss_empty;
	logic              rsd_full;
	logic              rsd_empty;
	logic              rsd_push;
	logic [DATA_W-1:0] rsd_in;

	// one request in flight, so a push never finds a full queue.
	assign o_req_rd = en_q && !rss_full && !rsd_full && !pend_q;
	assign req_fire = i_req_vld && o_req_rd;
	// range check against bank depth.
	assign in_range = (32'(i_req.addr) < 32'(MEM_DEPTH));
	assign idx      = i_req.addr[IDX_W-1:0];

	// reads only push data.
	assign rsd_push = pend_q && pend_rss.rnw;
	// zero data on an address error.
	assign rsd_in   = (pend_rss.err == ERR_OK) ? rdata_q : '0;

	// control state.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			en_q   <= 1'b0;
			pend_q <= 1'b0;
		end
		else
		begin
			// request side opens one cycle after reset.
			en_q   <= 1'b1;
			pend_q <= req_fire;
		end
	end

	// bank access and response payload.
	always_ff @(posedge clk)
	begin
		if (req_fire)
		begin
			pend_rss.cid <= i_req.cid;
			pend_rss.rnw <= i_req.rnw;
			pend_rss.err <= in_range ? ERR_OK : ERR_ADDR;
		end
		// bank untouched when out of range.
		if (req_fire && in_range)
		begin
			if (i_req.rnw)
			begin
				rdata_q <= bank[idx];
			end
			else
			begin
				bank[idx] <= i_req.wdata;
			end
		end
	end

	// status queue.
	mem_hub_fifo #(
		.WIDTH($bits(rss_t)),
		.DEPTH(RSP_DEPTH)
	) rss_fifo_inst (
		.clk(clk),
		.nrst(nrst),
		.i_push(pend_q),
		.i_data(pend_rss),
		.i_pop(o_rss_vld && i_rss_rd),
		.o_data(o_rss),
		.o_full(rss_full),
		.o_empty(rss_empty)
	);

	// data queue.
	mem_hub_fifo #(
		.WIDTH(DATA_W),
		.DEPTH(RSP_DEPTH)
	) rsd_fifo_inst (
		.clk(clk),
		.nrst(nrst),
		.i_push(rsd_push),
		.i_data(rsd_in),
		.i_pop(o_rsd_vld && i_rsd_rd),
		.o_data(o_rsd),
		.o_full(rsd_full),
		.o_empty(rsd_empty)
	);

	assign o_rss_vld = !rss_empty;
	assign o_rsd_vld = !rsd_empty;

	// an accepted request always finds room one cycle later.
	a_push_room: assert property (@(posedge clk) disable iff (!nrst)
		req_fire |=> !rss_full && (!pend_rss.rnw || !rsd_full));

endmodule

// File: src/mem_hub_cu_us.sv
`timescale 1ns/1ps

module mem_hub_cu_us
	import mem_hub_pkg::*;
(
	input  logic clk,
	input  logic nrst,
	input  logic i_m_sel,
	input  logic i_req_vld,
	input  req_t i_req,
	output logic o_req_rd,
	output logic o_m0_req_vld,
	output req_t o_m0_req,
	input  logic i_m0_req_rd,
	output logic o_m1_req_vld,
	output req_t o_m1_req,
	input  logic i_m1_req_rd
);
	logic en_q;
	// request register occupied.
	logic full_q;
	req_t req_q;
	logic sel_rd;
	logic drain;
	logic accept;

	// read strobe of the selected channel.
	assign sel_rd   = i_m_sel ? i_m1_req_rd : i_m0_req_rd;
	assign drain    = full_q && sel_rd;
	// take a new request when empty or draining.
	assign o_req_rd = en_q && (!full_q || sel_rd);
	assign accept   = i_req_vld && o_req_rd;

	// only the selected channel sees valid.
	assign o_m0_req_vld = full_q && !i_m_sel;
	assign o_m1_req_vld = full_q && i_m_sel;
	assign o_m0_req     = req_q;
	assign o_m1_req     = req_q;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			en_q   <= 1'b0;
			full_q <= 1'b0;
		end
		else
		begin
			en_q <= 1'b1;
			if (accept)
			begin
				full_q <= 1'b1;
			end
			else if (drain)
			begin
				full_q <= 1'b0;
			end
		end
	end

	// request payload.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req_q <= i_req;
		end
	end

	// channel select held while a request waits.
	a_sel_stable: assert property (@(posedge clk) disable iff (!nrst)
		full_q && $past(full_q) |-> $stable(i_m_sel));

endmodule

// File: src/mem_hub_cu_ds.sv
`timescale 1ns/1ps

module mem_hub_cu_ds
	import mem_hub_pkg::*;
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              i_m_sel,
	input  logic              i_rss_rdy,
	output rss_t              o_rss,
	output logic              o_rss_wr,
	input  logic              i_rsd_rdy,
	output logic [DATA_W-1:0] o_rsd,
	output logic              o_rsd_wr,
	input  logic              i_m0_rss_vld,
	input  rss_t              i_m0_rss,
	output logic              o_m0_rss_rd,
	input  logic              i_m0_rsd_vld,
	input  logic [DATA_W-1:0] i_m0_rsd,
	output logic              o_m0_rsd_rd,
	input  logic              i_m1_rss_vld,
	input  rss_t              i_m1_rss,
	output logic              o_m1_rss_rd,
	input  logic              i_m1_rsd_vld,
	input  logic [DATA_W-1:0] i_m1_rsd,
	output logic              o_m1_rsd_rd
);
	// selected channel streams.
	logic              m_rss_vld;
	rss_t              m_rss;
	logic              m_rss_rd;
	logic              m_rsd_vld;
	logic [DATA_W-1:0] m_rsd;
	logic              m_rsd_rd;
	// status FSM and its stash.
	skid_e             s_state;
	rss_t              s_stash_q;
	// data FSM and its stash.
	skid_e             d_state;
	logic [DATA_W-1:0] d_stash_q;

	// status mux, read strobe to the selected channel only.
	assign m_rss_vld   = i_m_sel ? i_m1_rss_vld : i_m0_rss_vld;
	assign m_rss       = i_m_sel ? i_m1_rss : i_m0_rss;
	assign o_m0_rss_rd = !i_m_sel && m_rss_rd;
	assign o_m1_rss_rd = i_m_sel && m_rss_rd;

	// data mux.
	assign m_rsd_vld   = i_m_sel ? i_m1_rsd_vld : i_m0_rsd_vld;
	assign m_rsd       = i_m_sel ? i_m1_rsd : i_m0_rsd;
	assign o_m0_rsd_rd = !i_m_sel && m_rsd_rd;
	assign o_m1_rsd_rd = i_m_sel && m_rsd_rd;

	// status skid FSM.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			s_state   <= SKID_IDLE;
			m_rss_rd  <= 1'b0;
			o_rss_wr  <= 1'b0;
			o_rss     <= '0;
			s_stash_q <= '0;
		end
		else
		begin
			case (s_state)
			SKID_RDXX:
			begin
				// first item, out on the next cycle.
				if (m_rss_vld)
				begin
					o_rss    <= m_rss;
					o_rss_wr <= 1'b1;
					s_state  <= SKID_RDWR;
				end
			end
			SKID_XXWR:
			begin
				// held item leaves, stash moves out.
				if (i_rss_rdy)
				begin
					o_rss    <= s_stash_q;
					m_rss_rd <= 1'b1;
					s_state  <= SKID_RDWR;
				end
			end
			SKID_RDWR:
			begin
				if (m_rss_vld && i_rss_rdy)
				begin
					o_rss <= m_rss;
				end
				else if (m_rss_vld && !i_rss_rdy)
				begin
					// item already read, keep it aside.
					s_stash_q <= m_rss;
					m_rss_rd  <= 1'b0;
					s_state   <= SKID_XXWR;
				end
				else if (!m_rss_vld && i_rss_rdy)
				begin
					o_rss_wr <= 1'b0;
					s_state  <= SKID_RDXX;
				end
			end
			default:
			begin
				// start reading the source.
				m_rss_rd <= 1'b1;
				s_state  <= SKID_RDXX;
			end
			endcase
		end
	end

	// data skid FSM, same scheme as status.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			d_state   <= SKID_IDLE;
			m_rsd_rd  <= 1'b0;
			o_rsd_wr  <= 1'b0;
			o_rsd     <= '0;
			d_stash_q <= '0;
		end
		else
		begin
			case (d_state)
			SKID_RDXX:
			begin
				if (m_rsd_vld)
				begin
					o_rsd    <= m_rsd;
					o_rsd_wr <= 1'b1;
					d_state  <= SKID_RDWR;
				end
			end
			SKID_XXWR:
			begin
				if (i_rsd_rdy)
				begin
					o_rsd    <= d_stash_q;
					m_rsd_rd <= 1'b1;
					d_state  <= SKID_RDWR;
				end
			end
			SKID_RDWR:
			begin
				if (m_rsd_vld && i_rsd_rdy)
				begin
					o_rsd <= m_rsd;
				end
				else if (m_rsd_vld && !i_rsd_rdy)
				begin
					d_stash_q <= m_rsd;
					m_rsd_rd  <= 1'b0;
					d_state   <= SKID_XXWR;
				end
				else if (!m_rsd_vld && i_rsd_rdy)
				begin
					o_rsd_wr <= 1'b0;
					d_state  <= SKID_RDXX;
				end
			end
			default:
			begin
				m_rsd_rd <= 1'b1;
				d_state  <= SKID_RDXX;
			end
			endcase
		end
	end

	// a stalled status holds until taken.
	a_rss_hold: assert property (@(posedge clk) disable iff (!nrst)
		o_rss_wr && !i_rss_rdy |=> o_rss_wr && $stable(o_rss));
	// a stalled data word holds until taken.
	a_rsd_hold: assert property (@(posedge clk) disable iff (!nrst)
		o_rsd_wr && !i_rsd_rdy |=> o_rsd_wr && $stable(o_rsd));

endmodule

// File: src/mem_hub_top.sv
`timescale 1ns/1ps

module mem_hub_top
	import mem_hub_pkg::*;
#(
	parameter int MEM_DEPTH = 256,
	parameter int RSP_DEPTH = 4
) (
	input  logic              clk,
	input  logic              nrst,
	input  logic              i_m_sel,
	input  logic              i_req_vld,
	input  req_t              i_req,
	output logic              o_req_rd,
	output rss_t              o_rss,
	output logic              o_rss_wr,
	input  logic              i_rss_rdy,
	output logic [DATA_W-1:0] o_rsd,
	output logic              o_rsd_wr,
	input  logic              i_rsd_rdy
);
	// request links to the channels.
	logic              m0_req_vld;
	req_t              m0_req;
	logic              m0_req_rd;
	logic              m1_req_vld;
	req_t              m1_req;
	logic              m1_req_rd;
	// response links from the channels.
	logic              m0_rss_vld;
	rss_t              m0_rss;
	logic              m0_rss_rd;
	logic              m0_rsd_vld;
	logic [DATA_W-1:0] m0_rsd;
	logic              m0_rsd_rd;
	logic              m1_rss_vld;
	rss_t              m1_rss;
	logic              m1_rss_rd;
	logic              m1_rsd_vld;
	logic [DATA_W-1:0] m1_rsd;
	logic              m1_rsd_rd;

	// request steering.
	mem_hub_cu_us cu_us_inst (
		.clk(clk),
		.nrst(nrst),
		.i_m_sel(i_m_sel),
		.i_req_vld(i_req_vld),
		.i_req(i_req),
		.o_req_rd(o_req_rd),
		.o_m0_req_vld(m0_req_vld),
		.o_m0_req(m0_req),
		.i_m0_req_rd(m0_req_rd),
		.o_m1_req_vld(m1_req_vld),
		.o_m1_req(m1_req),
		.i_m1_req_rd(m1_req_rd)
	);

	// channel 0.
	mem_hub_channel #(
		.MEM_DEPTH(MEM_DEPTH),
		.RSP_DEPTH(RSP_DEPTH)
	) channel0_inst (
		.clk(clk),
		.nrst(nrst),
		.i_req_vld(m0_req_vld),
		.i_req(m0_req),
		.o_req_rd(m0_req_rd),
		.o_rss_vld(m0_rss_vld),
		.o_rss(m0_rss),
		.i_rss_rd(m0_rss_rd),
		.o_rsd_vld(m0_rsd_vld),
		.o_rsd(m0_rsd),
		.i_rsd_rd(m0_rsd_rd)
	);

	// channel 1.
	mem_hub_channel #(
		.MEM_DEPTH(MEM_DEPTH),
		.RSP_DEPTH(RSP_DEPTH)
	) channel1_inst (
		.clk(clk),
		.nrst(nrst),
		.i_req_vld(m1_req_vld),
		.i_req(m1_req),
		.o_req_rd(m1_req_rd),
		.o_rss_vld(m1_rss_vld),
		.o_rss(m1_rss),
		.i_rss_rd(m1_rss_rd),
		.o_rsd_vld(m1_rsd_vld),
		.o_rsd(m1_rsd),
		.i_rsd_rd(m1_rsd_rd)
	);

	// response return path.
	mem_hub_cu_ds cu_ds_inst (
		.clk(clk),
		.nrst(nrst),
		.i_m_sel(i_m_sel),
		.i_rss_rdy(i_rss_rdy),
		.o_rss(o_rss),
		.o_rss_wr(o_rss_wr),
		.i_rsd_rdy(i_rsd_rdy),
		.o_rsd(o_rsd),
		.o_rsd_wr(o_rsd_wr),
		.i_m0_rss_vld(m0_rss_vld),
		.i_m0_rss(m0_rss),
		.o_m0_rss_rd(m0_rss_rd),
		.i_m0_rsd_vld(m0_rsd_vld),
		.i_m0_rsd(m0_rsd),
		.o_m0_rsd_rd(m0_rsd_rd),
		.i_m1_rss_vld(m1_rss_vld),
		.i_m1_rss(m1_rss),
		.o_m1_rss_rd(m1_rss_rd),
		.i_m1_rsd_vld(m1_rsd_vld),
		.i_m1_rsd(m1_rsd),
		.o_m1_rsd_rd(m1_rsd_rd)
	);

endmodule

// File: bench/mem_hub_tb.sv
`timescale 1ns/1ps

module mem_hub_tb
	import mem_hub_pkg::*;
();
	localparam int MEM_DEPTH = 256;
	// cycles allowed per wait.
	localparam int TIMEOUT = 2000;
	// room for every expected item of the run.
	localparam int EXP_MAX = 1024;

	logic              clk;
	logic              nrst;
	logic              i_m_sel;
	logic              i_req_vld;
	req_t              i_req;
	logic              o_req_rd;
	rss_t              o_rss;
	logic              o_rss_wr;
	logic              i_rss_rdy;
	logic [DATA_W-1:0] o_rsd;
	logic              o_rsd_wr;
	logic              i_rsd_rdy;

	// one bank model per channel.
	logic [DATA_W-1:0] bank_model [2][MEM_DEPTH];
	bit                written [2][MEM_DEPTH];
	// expected streams whose heads move on each transfer.
	rss_t              exp_rss [EXP_MAX];
	logic [DATA_W-1:0] exp_rsd [EXP_MAX];
	int                rss_head = 0;
	int                rss_tail = 0;
	int                rsd_head = 0;
	int                rsd_tail = 0;
	int                mismatches = 0;
	int                failures = 0;
	logic [CID_W-1:0]  cid_ctr;
	logic [31:0]       rng;
	logic              rand_rdy;
	logic              nrst_q = 1'b0;

	mem_hub_top #(
		.MEM_DEPTH(MEM_DEPTH),
		.RSP_DEPTH(4)
	) mem_hub_top_inst (
		.clk(clk),
		.nrst(nrst),
		.i_m_sel(i_m_sel),
		.i_req_vld(i_req_vld),
		.i_req(i_req),
		.o_req_rd(o_req_rd),
		.o_rss(o_rss),
		.o_rss_wr(o_rss_wr),
		.i_rss_rdy(i_rss_rdy),
		.o_rsd(o_rsd),
		.o_rsd_wr(o_rsd_wr),
		.i_rsd_rdy(i_rsd_rdy)
	);

	// 8 ns period.
	always #4 clk = ~clk;

	// reset seen one edge late.
	always @(posedge clk)
		nrst_q <= nrst;

	// heads advance on every output transfer.
	always @(posedge clk)
	begin
		if (nrst && o_rss_wr && i_rss_rdy)
			rss_head <= rss_head + 1;
		if (nrst && o_rsd_wr && i_rsd_rdy)
			rsd_head <= rsd_head + 1;
	end

	// quiet outputs in reset and on the first edge after.
	a_reset_quiet: assert property (@(posedge clk)
		!nrst || !nrst_q |-> !o_req_rd && !o_rss_wr && !o_rsd_wr)
		else
		begin
			failures++;
			$display("outputs active during or just after reset at %0t", $time);
		end

	// no status beyond what was requested.
	a_rss_expected: assert property (@(posedge clk) disable iff (!nrst)
		o_rss_wr && i_rss_rdy |-> rss_head < rss_tail)
		else
		begin
			failures++;
			$display("unexpected status transfer at %0t", $time);
		end

	// status equals the oldest expected one.
	a_rss_value: assert property (@(posedge clk) disable iff (!nrst)
		o_rss_wr && i_rss_rdy && rss_head < rss_tail |-> o_rss === exp_rss[rss_head])
		else
		begin
			mismatches++;
			$display("Mismatch at %0t: status %h, expected %h", $time,
				$sampled(o_rss), exp_rss[$sampled(rss_head)]);
		end

	// no data beyond the reads requested.
	a_rsd_expected: assert property (@(posedge clk) disable iff (!nrst)
		o_rsd_wr && i_rsd_rdy |-> rsd_head < rsd_tail)
		else
		begin
			failures++;
			$display("unexpected data transfer at %0t", $time);
		end

	// data equals the oldest expected word.
	a_rsd_value: assert property (@(posedge clk) disable iff (!nrst)
		o_rsd_wr && i_rsd_rdy && rsd_head < rsd_tail |-> o_rsd === exp_rsd[rsd_head])
		else
		begin
			mismatches++;
			$display("Mismatch at %0t: data %h, expected %h", $time,
				$sampled(o_rsd), exp_rsd[$sampled(rsd_head)]);
		end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// one cycle with inputs changed 1 ns after the edge.
	task automatic tick();
		@(posedge clk);
		#1;
		if (rand_rdy)
		begin
			rng = xorshift(rng);
			i_rss_rdy = rng[0];
			i_rsd_rdy = rng[5];
		end
		else
		begin
			i_rss_rdy = 1'b1;
			i_rsd_rdy = 1'b1;
		end
	endtask

	// issue one request and log what it must return.
	task automatic send_req(input logic rnw, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata);
		int   waited;
		logic ch;
		logic in_range;
		rss_t st;
		ch = i_m_sel;
		in_range = (addr < MEM_DEPTH);
		i_req.cid = cid_ctr;
		i_req.rnw = rnw;
		i_req.addr = addr;
		i_req.wdata = wdata;
		i_req_vld = 1'b1;
		waited = 0;
		// rd is settled here and holds to the next edge.
		while (!o_req_rd && waited < TIMEOUT)
		begin
			tick();
			waited++;
		end
		if (!o_req_rd)
		begin
			failures++;
			$display("timed out waiting for the request to be accepted at %0t", $time);
		end
		else
		begin
			st.cid = cid_ctr;
			st.rnw = rnw;
			st.err = in_range ? ERR_OK : ERR_ADDR;
			exp_rss[rss_tail] = st;
			rss_tail++;
			if (rnw)
			begin
				// zero data on an address error.
				if (in_range)
					exp_rsd[rsd_tail] = bank_model[ch][addr];
				else
					exp_rsd[rsd_tail] = '0;
				rsd_tail++;
			end
			else if (in_range)
			begin
				bank_model[ch][addr] = wdata;
				written[ch][addr] = 1'b1;
			end
			cid_ctr++;
		end
		tick();
		i_req_vld = 1'b0;
	endtask

	// wait until every expected item came out.
	task automatic drain();
		int waited;
		waited = 0;
		while ((rss_head != rss_tail || rsd_head != rsd_tail) && waited < TIMEOUT)
		begin
			tick();
			waited++;
		end
		if (rss_head != rss_tail || rsd_head != rsd_tail)
		begin
			failures++;
			$display("timed out waiting for responses at %0t", $time);
		end
	endtask

	// mixed reads and writes with some out of range.
	task automatic random_traffic(input int n);
		logic [ADDR_W-1:0] addr;
		logic              rnw;
		for (int i = 0; i < n; i++)
		begin
			rng = xorshift(rng);
			addr = {8'h00, rng[15:8]};
			if (rng[7:4] == 4'h0)
				addr = addr + 16'd256;
			// never read a word that was not written.
			rnw = rng[1] && (addr >= MEM_DEPTH || written[i_m_sel][addr[7:0]]);
			send_req(rnw, addr, {rng, ~rng});
			if (rng[2] && rng[3])
				tick();
		end
	endtask

	initial
	begin
		clk = 1'b0;
		nrst = 1'b1;
		i_m_sel = 1'b0;
		i_req_vld = 1'b0;
		i_req = '0;
		i_rss_rdy = 1'b1;
		i_rsd_rdy = 1'b1;
		rand_rdy = 1'b0;
		rng = 32'haec7;
		cid_ctr = '0;
		// asynchronous reset falls just after time zero.
		#1;
		nrst = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		nrst = 1'b1;
		tick();
		tick();

		// write then read back on channel 0.
		send_req(1'b0, 16'h0010, 64'hdead_beef_0123_4567);
		send_req(1'b1, 16'h0010, '0);
		drain();

		// out of range accesses leave word 0 intact.
		send_req(1'b0, 16'd0, 64'h1111_2222_3333_4444);
		send_req(1'b0, 16'd256, 64'h5555_6666_7777_8888);
		send_req(1'b1, 16'd256, '0);
		send_req(1'b1, 16'hffff, '0);
		send_req(1'b1, 16'd0, '0);
		drain();

		// same address holds its own word per bank.
		send_req(1'b0, 16'd5, 64'h0000_0000_c0c0_c0c0);
		drain();
		i_m_sel = 1'b1;
		tick();
		send_req(1'b0, 16'd5, 64'h0000_0000_c1c1_c1c1);
		send_req(1'b1, 16'd5, '0);
		drain();
		i_m_sel = 1'b0;
		tick();
		send_req(1'b1, 16'd5, '0);
		drain();

		// random stream under back-pressure on both channels.
		rand_rdy = 1'b1;
		random_traffic(150);
		drain();
		i_m_sel = 1'b1;
		tick();
		random_traffic(150);
		drain();
		rand_rdy = 1'b0;
		tick();
		tick();

		$display("errors: mismatches %0d, other failures %0d", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: sources.f
src/mem_hub_pkg.sv
src/mem_hub_fifo.sv
src/mem_hub_channel.sv
src/mem_hub_cu_us.sv
src/mem_hub_cu_ds.sv
src/mem_hub_top.sv
bench/mem_hub_tb.sv

// File: Bender.yml
package:
  name: mem_hub

sources:
  - src/mem_hub_pkg.sv
  - src/mem_hub_fifo.sv
  - src/mem_hub_channel.sv
  - src/mem_hub_cu_us.sv
  - src/mem_hub_cu_ds.sv
  - src/mem_hub_top.sv
  - target: test
    files:
      - bench/mem_hub_tb.sv
